// ==== Makefile ====
TOP := soc_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" sim.log; then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/bus_router.sv
hw/boot_rom.sv
hw/main_sram.sv
hw/clint_timer.sv
hw/soc_top.sv
verif/tb_clk_gen.sv
verif/soc_chk.sv
verif/soc_tb.sv

// ==== hw/boot_rom.sv ====
// Boot image from the shared package; one-cycle read, writes are silently dropped by having no port
`timescale 1ns/1ps

module boot_rom (
  input  logic                            clk_i,
  input  logic                            sel_i,
  input  logic [soc_pkg::RomIdxWidth-1:0] index_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o
);

  logic [soc_pkg::DataWidth-1:0] rdata_q;

  // Output holds the last word read
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= soc_pkg::BootImage[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/bus_arbiter.sv ====
// Round-robin between core and debug ports; responses must come exactly one cycle after grant
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              core_req_i,
  input  soc_pkg::bus_req_t core_cmd_i,
  output logic              core_gnt_o,
  output logic              core_rvalid_o,
  output soc_pkg::bus_rsp_t core_rsp_o,
  input  logic              dbg_req_i,
  input  soc_pkg::bus_req_t dbg_cmd_i,
  output logic              dbg_gnt_o,
  output logic              dbg_rvalid_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  output logic              bus_valid_o,
  output soc_pkg::bus_req_t bus_cmd_o,
  input  soc_pkg::bus_rsp_t rsp_i
);

  // Last winner, which is also the owner of the response in flight
  soc_pkg::master_e last_q;
  logic             pending_q;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------
  always_comb begin
    core_gnt_o = core_req_i && (!dbg_req_i || last_q == soc_pkg::MstDebug);
    dbg_gnt_o  = dbg_req_i && (!core_req_i || last_q == soc_pkg::MstCore);
  end

  assign bus_valid_o = core_gnt_o | dbg_gnt_o;
  assign bus_cmd_o   = dbg_gnt_o ? dbg_cmd_i : core_cmd_i;

  // Reset to debug so the core wins the first tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q    <= soc_pkg::MstDebug;
      pending_q <= 1'b0;
    end else begin
      pending_q <= bus_valid_o;
      if (bus_valid_o) begin
        last_q <= dbg_gnt_o ? soc_pkg::MstDebug : soc_pkg::MstCore;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response steering
  // ----------------------------------------------------------------------
  always_comb begin
    core_rvalid_o = pending_q && (last_q == soc_pkg::MstCore);
    dbg_rvalid_o  = pending_q && (last_q == soc_pkg::MstDebug);
    core_rsp_o    = '0;
    dbg_rsp_o     = '0;
    if (core_rvalid_o) core_rsp_o = rsp_i;
    if (dbg_rvalid_o) dbg_rsp_o = rsp_i;
  end

endmodule

// ==== hw/bus_router.sv ====
// Address decoder for ROM, SRAM and CLINT; unmapped accesses answer with err and zero data
`timescale 1ns/1ps

module bus_router #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 bus_valid_i,
  input  soc_pkg::bus_req_t                    bus_cmd_i,
  output soc_pkg::bus_rsp_t                    rsp_o,
  output logic                                 rom_sel_o,
  output logic [soc_pkg::RomIdxWidth-1:0]      rom_index_o,
  input  logic [soc_pkg::DataWidth-1:0]        rom_rdata_i,
  output logic                                 ram_sel_o,
  output logic [$clog2(RamWords)-1:0]          ram_index_o,
  input  logic [soc_pkg::DataWidth-1:0]        ram_rdata_i,
  output logic                                 clint_sel_o,
  output logic [soc_pkg::ClintOffWidth-1:0]    clint_offset_o,
  input  logic [soc_pkg::DataWidth-1:0]        clint_rdata_i,
  output logic                                 we_o,
  output logic [soc_pkg::BeWidth-1:0]          be_o,
  output logic [soc_pkg::DataWidth-1:0]        wdata_o
);

  localparam int unsigned RamIdxWidth = $clog2(RamWords);
  localparam int unsigned RamBytes    = RamWords * soc_pkg::BeWidth;

  logic [soc_pkg::AddrWidth-1:0] rom_off;
  logic [soc_pkg::AddrWidth-1:0] ram_off;
  logic [soc_pkg::AddrWidth-1:0] clint_off;
  soc_pkg::target_e              tgt;
  soc_pkg::target_e              tgt_q;
  logic                          valid_q;
  logic                          we_q;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  always_comb begin
    rom_off   = bus_cmd_i.addr - soc_pkg::RomBase;
    ram_off   = bus_cmd_i.addr - soc_pkg::RamBase;
    clint_off = bus_cmd_i.addr - soc_pkg::ClintBase;

    if (bus_cmd_i.addr >= soc_pkg::RomBase && rom_off < soc_pkg::RomLength) begin
      tgt = soc_pkg::TgtRom;
    end else if (bus_cmd_i.addr >= soc_pkg::RamBase && ram_off < RamBytes) begin
      tgt = soc_pkg::TgtRam;
    end else if (bus_cmd_i.addr >= soc_pkg::ClintBase &&
                 clint_off < soc_pkg::ClintLength) begin
      tgt = soc_pkg::TgtClint;
    end else begin
      tgt = soc_pkg::TgtErr;
    end
  end

  assign rom_sel_o   = bus_valid_i && (tgt == soc_pkg::TgtRom);
  assign ram_sel_o   = bus_valid_i && (tgt == soc_pkg::TgtRam);
  assign clint_sel_o = bus_valid_i && (tgt == soc_pkg::TgtClint);

  // ROM region is larger than the image, so upper index bits alias
  assign rom_index_o    = rom_off[soc_pkg::ByteOffBits +: soc_pkg::RomIdxWidth];
  assign ram_index_o    = ram_off[soc_pkg::ByteOffBits +: RamIdxWidth];
  assign clint_offset_o = clint_off[soc_pkg::ClintOffWidth-1:0];

  assign we_o    = bus_cmd_i.we;
  assign be_o    = bus_cmd_i.be;
  assign wdata_o = bus_cmd_i.wdata;

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tgt_q   <= soc_pkg::TgtErr;
      we_q    <= 1'b0;
    end else begin
      valid_q <= bus_valid_i;
      if (bus_valid_i) begin
        tgt_q <= tgt;
        we_q  <= bus_cmd_i.we;
      end
    end
  end

  // Write responses carry no data
  always_comb begin
    rsp_o = '0;
    if (valid_q) begin
      rsp_o.err = (tgt_q == soc_pkg::TgtErr);
      if (!we_q) begin
        unique case (tgt_q)
          soc_pkg::TgtRom:   rsp_o.rdata = rom_rdata_i;
          soc_pkg::TgtRam:   rsp_o.rdata = ram_rdata_i;
          soc_pkg::TgtClint: rsp_o.rdata = clint_rdata_i;
          default:           rsp_o.rdata = '0;
        endcase
      end
    end
  end

endmodule

// ==== hw/clint_timer.sv ====
// Single-hart CLINT; rtc_i must stay at least two clocks per level to be counted
`timescale 1ns/1ps

module clint_timer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              rtc_i,
  input  logic                              sel_i,
  input  logic                              we_i,
  input  logic [soc_pkg::ClintOffWidth-1:0] offset_i,
  input  logic [soc_pkg::BeWidth-1:0]       be_i,
  input  logic [soc_pkg::DataWidth-1:0]     wdata_i,
  output logic [soc_pkg::DataWidth-1:0]     rdata_o,
  output logic                              timer_irq_o,
  output logic                              ipi_o
);

  localparam int unsigned WordMsb = soc_pkg::ClintOffWidth - 1;
  localparam int unsigned WordLsb = soc_pkg::ByteOffBits;

  logic                          rtc_sync_q;
  logic                          rtc_prev_q;
  logic                          rtc_tick;
  logic                          msip_q;
  logic [soc_pkg::DataWidth-1:0] mtimecmp_q;
  logic [soc_pkg::DataWidth-1:0] mtime_q;
  logic [soc_pkg::DataWidth-1:0] rdata_q;
  logic                          hit_msip;
  logic                          hit_mtimecmp;
  logic                          hit_mtime;

  // Registers decode on 8-byte words, byte enables pick the lanes
  assign hit_msip     = offset_i[WordMsb:WordLsb] == soc_pkg::MsipOffset[WordMsb:WordLsb];
  assign hit_mtimecmp = offset_i[WordMsb:WordLsb] == soc_pkg::MtimecmpOffset[WordMsb:WordLsb];
  assign hit_mtime    = offset_i[WordMsb:WordLsb] == soc_pkg::MtimeOffset[WordMsb:WordLsb];

  assign rtc_tick = rtc_sync_q & ~rtc_prev_q;

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q  <= 1'b0;
      rtc_prev_q  <= 1'b0;
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_o <= 1'b0;
      ipi_o       <= 1'b0;
    end else begin
      rtc_sync_q  <= rtc_i;
      rtc_prev_q  <= rtc_sync_q;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      ipi_o       <= msip_q;

      if (sel_i && we_i && hit_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (sel_i && we_i && hit_mtimecmp) begin
        mtimecmp_q <= soc_pkg::be_merge(mtimecmp_q, wdata_i, be_i);
      end
      // A software write wins over a tick in the same cycle
      if (sel_i && we_i && hit_mtime) begin
        mtime_q <= soc_pkg::be_merge(mtime_q, wdata_i, be_i);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i && !we_i) begin
      if (hit_msip) begin
        rdata_q <= {{(soc_pkg::DataWidth-1){1'b0}}, msip_q};
      end else if (hit_mtimecmp) begin
        rdata_q <= mtimecmp_q;
      end else if (hit_mtime) begin
        rdata_q <= mtime_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/main_sram.sv ====
// Single-port word SRAM, one-cycle read; contents undefined until written
`timescale 1ns/1ps

module main_sram #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                              clk_i,
  input  logic                              sel_i,
  input  logic                              we_i,
  input  logic [$clog2(RamWords)-1:0]       index_i,
  input  logic [soc_pkg::BeWidth-1:0]       be_i,
  input  logic [soc_pkg::DataWidth-1:0]     wdata_i,
  output logic [soc_pkg::DataWidth-1:0]     rdata_o
);

  logic [soc_pkg::DataWidth-1:0] mem [RamWords];
  logic [soc_pkg::DataWidth-1:0] rdata_q;

  // ----------------------------------------------------------------------
  // Array access
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        // Only enabled byte lanes change
        mem[index_i] <= soc_pkg::be_merge(mem[index_i], wdata_i, be_i);
      end else begin
        rdata_q <= mem[index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/soc_pkg.sv ====
// Shared bus types and address map; 32-bit addresses, 64-bit data, little-endian byte lanes
package soc_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 64;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned ByteOffBits   = $clog2(BeWidth);
  localparam int unsigned ClintOffWidth = 16;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;
  localparam logic [AddrWidth-1:0] RamBase     = 32'h8000_0000;

  localparam logic [ClintOffWidth-1:0] MsipOffset     = 16'h0000;
  localparam logic [ClintOffWidth-1:0] MtimecmpOffset = 16'h4000;
  localparam logic [ClintOffWidth-1:0] MtimeOffset    = 16'hBFF8;

  // Boot image, word 0 at RomBase
  localparam int unsigned RomWords    = 8;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  localparam logic [0:RomWords-1][DataWidth-1:0] BootImage = '{
    64'h0000_0297_f140_2573,
    64'h0182_b283_0202_8593,
    64'h1050_0073_0002_8067,
    64'h8000_0537_0000_0013,
    64'h0005_0067_ffdf_f06f,
    64'hdead_beef_cafe_f00d,
    64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210
  };

  // ----------------------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

  typedef enum logic [1:0] {TgtRom, TgtRam, TgtClint, TgtErr} target_e;

  typedef enum logic {MstCore, MstDebug} master_e;

  // Merge enabled bytes of new_data into old_data
  function automatic logic [DataWidth-1:0] be_merge(input logic [DataWidth-1:0] old_data,
                                                    input logic [DataWidth-1:0] new_data,
                                                    input logic [BeWidth-1:0]   be);
    logic [DataWidth-1:0] res;
    res = old_data;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) res[i*8 +: 8] = new_data[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

// ==== hw/soc_top.sv ====
// Two-master bus fabric top; RamWords must be a power of two
`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned RamWords = 1024
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              core_req_i,
  input  soc_pkg::bus_req_t core_cmd_i,
  output logic              core_gnt_o,
  output logic              core_rvalid_o,
  output soc_pkg::bus_rsp_t core_rsp_o,
  input  logic              dbg_req_i,
  input  soc_pkg::bus_req_t dbg_cmd_i,
  output logic              dbg_gnt_o,
  output logic              dbg_rvalid_o,
  output soc_pkg::bus_rsp_t dbg_rsp_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  logic                              bus_valid;
  soc_pkg::bus_req_t                 bus_cmd;
  soc_pkg::bus_rsp_t                 bus_rsp;
  logic                              rom_sel;
  logic [soc_pkg::RomIdxWidth-1:0]   rom_index;
  logic [soc_pkg::DataWidth-1:0]     rom_rdata;
  logic                              ram_sel;
  logic [$clog2(RamWords)-1:0]       ram_index;
  logic [soc_pkg::DataWidth-1:0]     ram_rdata;
  logic                              clint_sel;
  logic [soc_pkg::ClintOffWidth-1:0] clint_offset;
  logic [soc_pkg::DataWidth-1:0]     clint_rdata;
  logic                              tgt_we;
  logic [soc_pkg::BeWidth-1:0]       tgt_be;
  logic [soc_pkg::DataWidth-1:0]     tgt_wdata;

  // ----------------------------------------------------------------------
  // Fabric
  // ----------------------------------------------------------------------
  bus_arbiter i_bus_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .core_req_i    ( core_req_i    ),
    .core_cmd_i    ( core_cmd_i    ),
    .core_gnt_o    ( core_gnt_o    ),
    .core_rvalid_o ( core_rvalid_o ),
    .core_rsp_o    ( core_rsp_o    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_cmd_i     ( dbg_cmd_i     ),
    .dbg_gnt_o     ( dbg_gnt_o     ),
    .dbg_rvalid_o  ( dbg_rvalid_o  ),
    .dbg_rsp_o     ( dbg_rsp_o     ),
    .bus_valid_o   ( bus_valid     ),
    .bus_cmd_o     ( bus_cmd       ),
    .rsp_i         ( bus_rsp       )
  );

  bus_router #(
    .RamWords ( RamWords )
  ) i_bus_router (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .bus_valid_i    ( bus_valid    ),
    .bus_cmd_i      ( bus_cmd      ),
    .rsp_o          ( bus_rsp      ),
    .rom_sel_o      ( rom_sel      ),
    .rom_index_o    ( rom_index    ),
    .rom_rdata_i    ( rom_rdata    ),
    .ram_sel_o      ( ram_sel      ),
    .ram_index_o    ( ram_index    ),
    .ram_rdata_i    ( ram_rdata    ),
    .clint_sel_o    ( clint_sel    ),
    .clint_offset_o ( clint_offset ),
    .clint_rdata_i  ( clint_rdata  ),
    .we_o           ( tgt_we       ),
    .be_o           ( tgt_be       ),
    .wdata_o        ( tgt_wdata    )
  );

  // ----------------------------------------------------------------------
  // Targets
  // ----------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .sel_i   ( rom_sel   ),
    .index_i ( rom_index ),
    .rdata_o ( rom_rdata )
  );

  main_sram #(
    .RamWords ( RamWords )
  ) i_main_sram (
    .clk_i   ( clk_i     ),
    .sel_i   ( ram_sel   ),
    .we_i    ( tgt_we    ),
    .index_i ( ram_index ),
    .be_i    ( tgt_be    ),
    .wdata_i ( tgt_wdata ),
    .rdata_o ( ram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .rtc_i       ( rtc_i        ),
    .sel_i       ( clint_sel    ),
    .we_i        ( tgt_we       ),
    .offset_i    ( clint_offset ),
    .be_i        ( tgt_be       ),
    .wdata_i     ( tgt_wdata    ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq_o  ),
    .ipi_o       ( ipi_o        )
  );

endmodule

// ==== verif/soc_chk.sv ====
// Handshake properties for bus_arbiter; only meaningful while rst_ni is high
`timescale 1ns/1ps

module soc_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic core_req_i,
  input logic dbg_req_i,
  input logic core_gnt_o,
  input logic dbg_gnt_o,
  input logic core_rvalid_o,
  input logic dbg_rvalid_o
);

  int unsigned assert_fails = 0;

  // ----------------------------------------------------------------------
  // Grant rules
  // ----------------------------------------------------------------------
  a_core_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_gnt_o |-> core_req_i)
    else begin
      assert_fails++;
      $error("core grant without a core request");
    end
  a_dbg_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_gnt_o |-> dbg_req_i)
    else begin
      assert_fails++;
      $error("debug grant without a debug request");
    end
  a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_gnt_o && dbg_gnt_o))
    else begin
      assert_fails++;
      $error("both masters granted in one cycle");
    end

  // ----------------------------------------------------------------------
  // Response follows grant by one cycle
  // ----------------------------------------------------------------------
  a_core_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_gnt_o |=> core_rvalid_o)
    else begin
      assert_fails++;
      $error("core grant not followed by core rvalid");
    end
  a_dbg_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_gnt_o |=> dbg_rvalid_o)
    else begin
      assert_fails++;
      $error("debug grant not followed by debug rvalid");
    end
  a_core_stray: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rvalid_o |-> $past(core_gnt_o))
    else begin
      assert_fails++;
      $error("core rvalid without an earlier grant");
    end
  a_dbg_stray: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_rvalid_o |-> $past(dbg_gnt_o))
    else begin
      assert_fails++;
      $error("debug rvalid without an earlier grant");
    end

endmodule

bind bus_arbiter soc_chk i_soc_chk (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .core_req_i    ( core_req_i    ),
  .dbg_req_i     ( dbg_req_i     ),
  .core_gnt_o    ( core_gnt_o    ),
  .dbg_gnt_o     ( dbg_gnt_o     ),
  .core_rvalid_o ( core_rvalid_o ),
  .dbg_rvalid_o  ( dbg_rvalid_o  )
);

// ==== verif/soc_tb.sv ====
// Testbench for soc_top; RAM checks use the first 16 words only, rtc is driven by the testbench
`timescale 1ns/1ps

module soc_tb;

  localparam int unsigned RamWords      = 1024;
  localparam int unsigned RamTestWords  = 16;
  localparam int unsigned PartialWrites = 24;
  localparam int unsigned ArbRounds     = 16;
  localparam int unsigned RtcPulses     = 10;
  localparam logic [63:0] CmpValue      = 64'd6;
  localparam logic [31:0] Seed          = 32'h6d9330fb;
  localparam logic [31:0] ErrAddr       = 32'h4000_0000;

  // Cycle cost per test, a single access takes at most 4 cycles
  localparam int unsigned RomCycles   = (2 * soc_pkg::RomWords + 2) * 4;
  localparam int unsigned RamCycles   = (2 * RamTestWords + PartialWrites) * 4;
  localparam int unsigned ErrCycles   = 7 * 4;
  localparam int unsigned ArbCycles   = ArbRounds + 4;
  localparam int unsigned ClintCycles = RtcPulses * (9 + 4) + 6 * 4;
  localparam int unsigned CycleLimit  =
    2 * (RomCycles + RamCycles + ErrCycles + ArbCycles + ClintCycles) + 100;

  logic              clk;
  logic              rst_n;
  logic              rtc;
  logic              core_req;
  soc_pkg::bus_req_t core_cmd;
  logic              core_gnt;
  logic              core_rvalid;
  soc_pkg::bus_rsp_t core_rsp;
  logic              dbg_req;
  soc_pkg::bus_req_t dbg_cmd;
  logic              dbg_gnt;
  logic              dbg_rvalid;
  soc_pkg::bus_rsp_t dbg_rsp;
  logic              timer_irq;
  logic              ipi;

  soc_pkg::master_e  last_win;
  logic [63:0]       ram_model [RamTestWords];
  logic [31:0]       rng_state;
  int unsigned       checks;
  int unsigned       errors;
  int unsigned       cycle_count;
  int unsigned       rtc_count;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_top #(
    .RamWords ( RamWords )
  ) UUT (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .rtc_i         ( rtc         ),
    .core_req_i    ( core_req    ),
    .core_cmd_i    ( core_cmd    ),
    .core_gnt_o    ( core_gnt    ),
    .core_rvalid_o ( core_rvalid ),
    .core_rsp_o    ( core_rsp    ),
    .dbg_req_i     ( dbg_req     ),
    .dbg_cmd_i     ( dbg_cmd     ),
    .dbg_gnt_o     ( dbg_gnt     ),
    .dbg_rvalid_o  ( dbg_rvalid  ),
    .dbg_rsp_o     ( dbg_rsp     ),
    .timer_irq_o   ( timer_irq   ),
    .ipi_o         ( ipi         )
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Model of a byte-enabled word write
  function automatic logic [63:0] byte_merge(input logic [63:0] old_w,
                                             input logic [63:0] new_w,
                                             input logic [7:0]  be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic soc_pkg::bus_req_t make_cmd(input logic [31:0] addr, input logic we,
                                                 input logic [7:0] be, input logic [63:0] wdata);
    soc_pkg::bus_req_t cmd;
    cmd.addr  = addr;
    cmd.we    = we;
    cmd.be    = be;
    cmd.wdata = wdata;
    return cmd;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic expect_response(input logic use_dbg, input logic [63:0] exp_rdata,
                                 input logic exp_err);
    if (use_dbg) begin
      compare_value("dbg_rvalid_o", dbg_rvalid, 1'b1);
      compare_value("core_rvalid_o", core_rvalid, 1'b0);
      compare_value("dbg_rsp_o.rdata", dbg_rsp.rdata, exp_rdata);
      compare_value("dbg_rsp_o.err", dbg_rsp.err, exp_err);
    end else begin
      compare_value("core_rvalid_o", core_rvalid, 1'b1);
      compare_value("dbg_rvalid_o", dbg_rvalid, 1'b0);
      compare_value("core_rsp_o.rdata", core_rsp.rdata, exp_rdata);
      compare_value("core_rsp_o.err", core_rsp.err, exp_err);
    end
  endtask

  // One transfer from a single master; samples 1 ns after each falling edge
  task automatic bus_access(input logic use_dbg, input logic [31:0] addr, input logic we,
                            input logic [7:0] be, input logic [63:0] wdata,
                            input logic [63:0] exp_rdata, input logic exp_err);
    logic granted;
    granted = 1'b0;
    @(negedge clk);
    if (use_dbg) begin
      dbg_req = 1'b1;
      dbg_cmd = make_cmd(addr, we, be, wdata);
    end else begin
      core_req = 1'b1;
      core_cmd = make_cmd(addr, we, be, wdata);
    end
    while (!granted) begin
      #1;
      granted = use_dbg ? dbg_gnt : core_gnt;
      @(negedge clk);
    end
    core_req = 1'b0;
    dbg_req  = 1'b0;
    last_win = use_dbg ? soc_pkg::MstDebug : soc_pkg::MstCore;
    #1;
    expect_response(use_dbg, exp_rdata, exp_err);
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic rom_test();
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      bus_access(1'b0, soc_pkg::RomBase + i * 8, 1'b0, 8'hff, '0, soc_pkg::BootImage[i], 1'b0);
      bus_access(1'b1, soc_pkg::RomBase + i * 8, 1'b0, 8'hff, '0, soc_pkg::BootImage[i], 1'b0);
    end
    bus_access(1'b0, soc_pkg::RomBase + 8, 1'b1, 8'hff, {xorshift32(), xorshift32()}, '0, 1'b0);
    bus_access(1'b1, soc_pkg::RomBase + 8, 1'b0, 8'hff, '0, soc_pkg::BootImage[1], 1'b0);
  endtask

  task automatic ram_test();
    logic [63:0] wdata;
    logic [31:0] r;
    int unsigned idx;
    for (int i = 0; i < RamTestWords; i++) begin
      wdata        = {xorshift32(), xorshift32()};
      ram_model[i] = wdata;
      r            = xorshift32();
      bus_access(r[0], soc_pkg::RamBase + i * 8, 1'b1, 8'hff, wdata, '0, 1'b0);
    end
    for (int i = 0; i < PartialWrites; i++) begin
      r              = xorshift32();
      idx            = r[11:8] % RamTestWords;
      wdata          = {xorshift32(), xorshift32()};
      ram_model[idx] = byte_merge(ram_model[idx], wdata, r[7:0]);
      bus_access(r[16], soc_pkg::RamBase + idx * 8, 1'b1, r[7:0], wdata, '0, 1'b0);
    end
    for (int i = 0; i < RamTestWords; i++) begin
      r = xorshift32();
      bus_access(r[0], soc_pkg::RamBase + i * 8, 1'b0, 8'hff, '0, ram_model[i], 1'b0);
    end
  endtask

  task automatic error_test();
    bus_access(1'b0, ErrAddr, 1'b0, 8'hff, '0, '0, 1'b1);
    bus_access(1'b1, ErrAddr, 1'b1, 8'hff, {xorshift32(), xorshift32()}, '0, 1'b1);
    bus_access(1'b0, ErrAddr, 1'b0, 8'hff, '0, '0, 1'b1);
    bus_access(1'b1, 32'h0000_0008, 1'b0, 8'hff, '0, '0, 1'b1);
    // Just past the end of the SRAM
    bus_access(1'b0, soc_pkg::RamBase + RamWords * 8, 1'b1, 8'hff, '1, '0, 1'b1);
    bus_access(1'b1, soc_pkg::RamBase, 1'b0, 8'hff, '0, ram_model[0], 1'b0);
    bus_access(1'b0, soc_pkg::RomBase, 1'b0, 8'hff, '0, soc_pkg::BootImage[0], 1'b0);
  endtask

  // Both masters request every cycle, core reads ROM and debug reads SRAM
  task automatic arbitration_test();
    int unsigned ci;
    int unsigned di;
    logic        pend;
    logic        pend_dbg;
    logic [63:0] pend_data;
    logic        exp_dbg;
    ci   = 0;
    di   = 0;
    pend = 1'b0;
    @(negedge clk);
    core_req = 1'b1;
    dbg_req  = 1'b1;
    core_cmd = make_cmd(soc_pkg::RomBase, 1'b0, 8'hff, '0);
    dbg_cmd  = make_cmd(soc_pkg::RamBase, 1'b0, 8'hff, '0);
    for (int n = 0; n < ArbRounds; n++) begin
      #1;
      if (pend) expect_response(pend_dbg, pend_data, 1'b0);
      exp_dbg = (last_win == soc_pkg::MstCore);
      compare_value("core_gnt_o", core_gnt, !exp_dbg);
      compare_value("dbg_gnt_o", dbg_gnt, exp_dbg);
      pend      = 1'b1;
      pend_dbg  = exp_dbg;
      pend_data = exp_dbg ? ram_model[di] : soc_pkg::BootImage[ci];
      last_win  = exp_dbg ? soc_pkg::MstDebug : soc_pkg::MstCore;
      @(negedge clk);
      if (exp_dbg) begin
        di      = (di + 1) % RamTestWords;
        dbg_cmd = make_cmd(soc_pkg::RamBase + di * 8, 1'b0, 8'hff, '0);
      end else begin
        ci       = (ci + 1) % soc_pkg::RomWords;
        core_cmd = make_cmd(soc_pkg::RomBase + ci * 8, 1'b0, 8'hff, '0);
      end
    end
    core_req = 1'b0;
    dbg_req  = 1'b0;
    #1;
    expect_response(pend_dbg, pend_data, 1'b0);
  endtask

  task automatic clint_test();
    logic [31:0] r;
    bus_access(1'b0, soc_pkg::ClintBase + soc_pkg::MsipOffset, 1'b1, 8'h01, 64'h1, '0, 1'b0);
    @(negedge clk);
    #1;
    compare_value("ipi_o", ipi, 1'b1);
    bus_access(1'b1, soc_pkg::ClintBase + soc_pkg::MsipOffset, 1'b1, 8'h01, 64'h0, '0, 1'b0);
    @(negedge clk);
    #1;
    compare_value("ipi_o", ipi, 1'b0);
    bus_access(1'b0, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, 1'b1, 8'hff, CmpValue,
               '0, 1'b0);
    bus_access(1'b1, soc_pkg::ClintBase + soc_pkg::MtimecmpOffset, 1'b0, 8'hff, '0,
               CmpValue, 1'b0);
    for (int p = 0; p < RtcPulses; p++) begin
      @(negedge clk);
      rtc = 1'b1;
      repeat (4) @(negedge clk);
      rtc = 1'b0;
      rtc_count++;
      repeat (4) @(negedge clk);
      #1;
      compare_value("timer_irq_o", timer_irq, rtc_count >= CmpValue);
      r = xorshift32();
      bus_access(r[0], soc_pkg::ClintBase + soc_pkg::MtimeOffset, 1'b0, 8'hff, '0,
                 rtc_count, 1'b0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rng_state   = Seed;
    checks      = 0;
    errors      = 0;
    cycle_count = 0;
    rtc_count   = 0;
    last_win    = soc_pkg::MstDebug;
    rtc         = 1'b0;
    core_req    = 1'b0;
    core_cmd    = '0;
    dbg_req     = 1'b0;
    dbg_cmd     = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    #1;
    compare_value("core_rvalid_o", core_rvalid, 1'b0);
    compare_value("dbg_rvalid_o", dbg_rvalid, 1'b0);
    compare_value("timer_irq_o", timer_irq, 1'b0);
    compare_value("ipi_o", ipi, 1'b0);
    rom_test();
    ram_test();
    error_test();
    arbitration_test();
    clint_test();
    repeat (2) @(negedge clk);
    $display("Summary: %0d checks, %0d check errors, %0d assertion errors", checks, errors,
             UUT.i_bus_arbiter.i_soc_chk.assert_fails);
    if (errors == 0 && UUT.i_bus_arbiter.i_soc_chk.assert_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clk_gen.sv ====
// 4 ns free-running clock; reset held low for four rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule
